// ==== test/sd_probe_stim.txt ====
# fill_count (decimal)  r1 (hex)  expected text after the banner
# text -- means no R1 arrived within the 8 polls
0 01 01
2 05 05
7 00 00
3 7F 7F
1 1A 1A
8 01 --
10 00 --

// ==== verilog.f ====
logic/sd_pkg.sv
logic/dbg_pkg.sv
logic/sd_cmd_sequencer.sv
logic/spi_byte_master.sv
logic/r1_reporter.sv
logic/serial_tx.sv
logic/sd_probe_top.sv
test/sd_probe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the SD probe testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module sd_probe_tb -f verilog.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vsd_probe_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// ==== test/sd_probe_tb.sv ====
// Testbench for the SD probe top level that runs every case listed in test/sd_probe_stim.txt
`timescale 1ns/1ps

module sd_probe_tb
    import sd_pkg::*;
();

    localparam int clk_period_ns   = 100;
    localparam int startup_cycles  = 20;
    localparam int spi_half_period = 2;
    localparam int baud_div        = 8;
    localparam int poll_limit      = 8;
    // Reset, startup, up to 30 SPI bytes and 6 serial characters
    localparam longint case_cycles = 4 + startup_cycles + 30 * (16 * spi_half_period + 4)
                                     + 6 * (10 * baud_div + 4);

    // CMD0 with its fixed CRC as the card expects it
    localparam logic [7:0] cmd0_bytes [6] = '{8'h40, 8'h00, 8'h00, 8'h00, 8'h00, 8'h95};

    logic        CLOCK_50     = 1'b0;
    logic        KEY0         = 1'b0;
    logic        SPI_MISO     = 1'b1;
    logic        SPI_SCLK;
    logic        SPI_MOSI;
    logic        SPI_SS_n;
    logic        UART_TXD;
    logic        LEDR0;

    int          cur_fill     = 0;
    logic [7:0]  cur_r1       = 8'h00;
    logic        cases_loaded = 1'b0;
    int          num_cases    = 0;
    int          fill_q [$];
    logic [7:0]  r1_q [$];
    logic [15:0] text_q [$];

    sd_probe_top #(
        .startup_cycles  (startup_cycles),
        .spi_half_period (spi_half_period),
        .baud_div        (baud_div)
    ) i_sd_probe_top (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .SPI_MISO (SPI_MISO),
        .SPI_SCLK (SPI_SCLK),
        .SPI_MOSI (SPI_MOSI),
        .SPI_SS_n (SPI_SS_n),
        .UART_TXD (UART_TXD),
        .LEDR0    (LEDR0)
    );

    always #(clk_period_ns / 2) CLOCK_50 = ~CLOCK_50;

    // ============================================================
    // Checks
    // ============================================================
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0d ns: %s got 8'h%02h expected 8'h%02h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0d ns: %s got %0b expected %0b",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_r1(input string name, input r1_t got, input r1_t exp);
        if (got.flags.in_idle !== exp.flags.in_idle) begin
            fail_run($sformatf("Mismatch at %0d ns: %s in_idle got %0b expected %0b",
                               $time, name, got.flags.in_idle, exp.flags.in_idle));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("Mismatch at %0d ns: %s got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    // ============================================================
    // SD card model in SPI mode 0
    // ============================================================
    logic       prev_sclk = 1'b0;
    logic [7:0] mosi_shift;
    logic [7:0] miso_shift;
    int         bit_cnt;
    int         byte_cnt;

    // Card answers FF except for the one R1 slot after the fill bytes
    function automatic logic [7:0] card_reply(input int idx);
        if (idx == 6 + cur_fill) begin
            return cur_r1;
        end
        return 8'hFF;
    endfunction

    always @(posedge CLOCK_50) begin
        logic [7:0] rx_byte;
        logic [7:0] next_byte;
        prev_sclk <= SPI_SCLK;
        if (!KEY0 || SPI_SS_n) begin
            bit_cnt    <= 0;
            miso_shift <= 8'hFF;
            SPI_MISO   <= 1'b1;
            if (!KEY0) begin
                byte_cnt <= 0;
            end
        end else if (SPI_SCLK && !prev_sclk) begin
            rx_byte = {mosi_shift[6:0], SPI_MOSI};
            mosi_shift <= rx_byte;
            bit_cnt    <= bit_cnt + 1;
            if (bit_cnt == 7 && byte_cnt < 6) begin
                check_byte($sformatf("SPI_MOSI frame byte %0d", byte_cnt), rx_byte,
                           cmd0_bytes[byte_cnt]);
            end else if (bit_cnt == 7) begin
                check_byte("SPI_MOSI fill byte", rx_byte, 8'hFF);
            end
        end else if (!SPI_SCLK && prev_sclk) begin
            if (bit_cnt == 8) begin
                // Next reply goes out before the next rising edge
                next_byte = card_reply(byte_cnt + 1);
                byte_cnt   <= byte_cnt + 1;
                bit_cnt    <= 0;
                miso_shift <= next_byte;
                SPI_MISO   <= next_byte[7];
            end else begin
                miso_shift <= {miso_shift[6:0], 1'b1};
                SPI_MISO   <= miso_shift[6];
            end
        end
    end

    // ============================================================
    // Serial decoder sampling at mid-bit
    // ============================================================
    int         rx_wait;
    int         rx_bit;
    logic       rx_active;
    logic [7:0] rx_data;
    logic [7:0] rx_chars [$];

    always @(posedge CLOCK_50) begin
        if (!KEY0) begin
            rx_active <= 1'b0;
            rx_wait   <= 0;
            rx_bit    <= 0;
            rx_chars.delete();
        end else if (!rx_active) begin
            if (!UART_TXD) begin
                rx_active <= 1'b1;
                rx_wait   <= baud_div / 2;
                rx_bit    <= 0;
            end
        end else if (rx_wait > 1) begin
            rx_wait <= rx_wait - 1;
        end else begin
            rx_wait <= baud_div;
            rx_bit  <= rx_bit + 1;
            if (rx_bit == 0 && UART_TXD) begin
                fail_run("The serial start bit on UART_TXD did not last to mid-bit");
            end else if (rx_bit == 9 && !UART_TXD) begin
                fail_run("The serial stop bit on UART_TXD is missing");
            end else if (rx_bit == 9) begin
                rx_chars.push_back(rx_data);
                rx_active <= 1'b0;
            end else if (rx_bit != 0) begin
                rx_data <= {UART_TXD, rx_data[7:1]};
            end
        end
    end

    // Columns are fill count, R1 in hex and the expected two-character text
    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        int          fill;
        logic [7:0]  r1v;
        logic [15:0] txt;
        fd = $fopen("test/sd_probe_stim.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open the stimulus file test/sd_probe_stim.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %s", fill, r1v, txt);
                    if (n != 3) begin
                        fail_run($sformatf("Malformed stimulus line: %s", line));
                    end else begin
                        fill_q.push_back(fill);
                        r1_q.push_back(r1v);
                        text_q.push_back(txt);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin : main
        int   i;
        int   exp_bytes;
        logic timeout;
        r1_t  got_r1;
        r1_t  exp_r1;
        load_stimulus();
        num_cases    = fill_q.size();
        cases_loaded = 1'b1;
        for (i = 0; i < num_cases; i++) begin
            @(posedge CLOCK_50);
            KEY0     <= 1'b0;
            cur_fill <= fill_q[i];
            cur_r1   <= r1_q[i];
            repeat (4) @(posedge CLOCK_50);
            check_bit("SPI_SS_n in reset", SPI_SS_n, 1'b1);
            check_bit("UART_TXD in reset", UART_TXD, 1'b1);
            check_bit("SPI_SCLK in reset", SPI_SCLK, 1'b0);
            check_bit("LEDR0 in reset", LEDR0, 1'b0);
            KEY0 <= 1'b1;
            $display("Case %0d: %0d fill bytes, R1 %02h", i, fill_q[i], r1_q[i]);

            // Banner, two hex digits and the line feed
            while (rx_chars.size() < 6) begin
                @(posedge CLOCK_50);
            end
            check_byte("UART_TXD char 0", rx_chars[0], "S");
            check_byte("UART_TXD char 1", rx_chars[1], "D");
            check_byte("UART_TXD char 2", rx_chars[2], " ");
            check_byte("UART_TXD char 3", rx_chars[3], text_q[i][15:8]);
            check_byte("UART_TXD char 4", rx_chars[4], text_q[i][7:0]);
            check_byte("UART_TXD char 5", rx_chars[5], 8'h0A);

            timeout    = (fill_q[i] >= poll_limit);
            exp_bytes  = timeout ? 6 + poll_limit : 7 + fill_q[i];
            got_r1.raw = {7'b0, LEDR0};
            exp_r1.raw = timeout ? 8'h00 : r1_q[i];
            check_r1("LEDR0", got_r1, exp_r1);
            check_bit("SPI_SS_n after the report", SPI_SS_n, 1'b1);
            check_count("SPI byte count", byte_cnt, exp_bytes);
        end
        if (num_cases == 0) begin
            fail_run("The stimulus file holds no test cases");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    // Limit of twice the worst case per test
    initial begin : watchdog
        longint limit_ns;
        wait (cases_loaded);
        limit_ns = 2 * case_cycles * num_cases * clk_period_ns;
        #(limit_ns);
        fail_run("Timeout, the probe did not finish all cases in time");
    end

endmodule

// ==== logic/sd_probe_top.sv ====
// Board top of the SD card probe, wires sequencer, SPI master, reporter and serial line to pins
`timescale 1ns/1ps

module sd_probe_top
    import sd_pkg::*;
    import dbg_pkg::*;
#(
    parameter int startup_cycles  = 4_000_000,
    parameter int spi_half_period = 64,
    parameter int baud_div        = 434
) (
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic SPI_MISO,
    output logic SPI_SCLK,
    output logic SPI_MOSI,
    output logic SPI_SS_n,
    output logic UART_TXD,
    output logic LEDR0
);

    spi_req_t   spi_req;
    spi_rsp_t   spi_rsp;
    logic       spi_busy;
    logic       banner;
    r1_result_t result;
    dbg_char_t  tx_char;
    logic       tx_busy;

    // ============================================================
    // Probe pipeline
    // ============================================================
    sd_cmd_sequencer #(
        .startup_cycles(startup_cycles)
    ) i_sd_cmd_sequencer (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .spi_rsp  (spi_rsp),
        .spi_busy (spi_busy),
        .spi_req  (spi_req),
        .ss_n     (SPI_SS_n),
        .banner   (banner),
        .result   (result)
    );

    spi_byte_master #(
        .spi_half_period(spi_half_period)
    ) i_spi_byte_master (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (spi_req),
        .miso     (SPI_MISO),
        .rsp      (spi_rsp),
        .busy     (spi_busy),
        .sclk     (SPI_SCLK),
        .mosi     (SPI_MOSI)
    );

    r1_reporter i_r1_reporter (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .banner   (banner),
        .result   (result),
        .tx_busy  (tx_busy),
        .tx_char  (tx_char)
    );

    serial_tx #(
        .baud_div(baud_div)
    ) i_serial_tx (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .char_in  (tx_char),
        .busy     (tx_busy),
        .txd      (UART_TXD)
    );

    // Idle flag of the last response, off when the card never answered
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            LEDR0 <= 1'b0;
        end else if (result.valid) begin
            LEDR0 <= result.r1.flags.in_idle & ~result.timeout;
        end
    end

endmodule

// ==== logic/serial_tx.sv ====
// 8N1 serial transmitter for the debug line, one character per valid strobe
`timescale 1ns/1ps

module serial_tx
    import dbg_pkg::*;
#(
    parameter int baud_div = 434
) (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  dbg_char_t char_in,
    output logic      busy,
    output logic      txd
);

    localparam int cnt_w = $clog2(baud_div + 1);

    logic [cnt_w-1:0] baud_cnt;
    logic [3:0]       bit_cnt;
    // Stop bit, data LSB first, start bit in bit 0
    logic [9:0]       frame;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            frame    <= '1;
        end else if (!busy) begin
            if (char_in.valid) begin
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
                frame    <= {1'b1, char_in.code, 1'b0};
            end
        end else if (baud_cnt == cnt_w'(baud_div - 1)) begin
            baud_cnt <= '0;
            // Ones shift in so the line idles high
            frame    <= {1'b1, frame[9:1]};
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign txd = frame[0];

endmodule

// ==== logic/r1_reporter.sv ====
// Turns the banner strobe and the R1 result into debug characters for the serial transmitter
`timescale 1ns/1ps

module r1_reporter
    import sd_pkg::*;
    import dbg_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       banner,
    input  r1_result_t result,
    input  logic       tx_busy,
    output dbg_char_t  tx_char
);

    logic [0:banner_len-1][7:0] queue;
    logic [1:0]                 count;
    logic                       banner_pend;
    logic                       result_pend;
    logic                       held_timeout;
    r1_t                        held_r1;

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return ascii_zero + 8'(nib);
        end
        return ascii_upper_a + 8'(nib) - 8'd10;
    endfunction

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            queue        <= '0;
            count        <= '0;
            banner_pend  <= 1'b0;
            result_pend  <= 1'b0;
            held_timeout <= 1'b0;
            held_r1      <= '0;
            tx_char      <= '0;
        end else begin
            tx_char.valid <= 1'b0;

            // Hold requests until the queue has drained
            if (banner) begin
                banner_pend <= 1'b1;
            end
            if (result.valid) begin
                result_pend  <= 1'b1;
                held_timeout <= result.timeout;
                held_r1      <= result.r1;
            end

            if (count == 2'd0) begin
                if (banner_pend) begin
                    queue       <= banner_text;
                    count       <= 2'(banner_len);
                    banner_pend <= 1'b0;
                end else if (result_pend) begin
                    if (held_timeout) begin
                        queue <= {ascii_dash, ascii_dash, ascii_lf};
                    end else begin
                        queue <= {hex_char(held_r1.raw[7:4]), hex_char(held_r1.raw[3:0]),
                                  ascii_lf};
                    end
                    count       <= 2'd3;
                    result_pend <= 1'b0;
                end
            end else if (!tx_busy && !tx_char.valid) begin
                // Busy rises a cycle after valid, so skip the cycle after a send
                tx_char.valid <= 1'b1;
                tx_char.code  <= queue[0];
                queue         <= {queue[1], queue[2], 8'h00};
                count         <= count - 1'b1;
            end
        end
    end

endmodule

// ==== logic/spi_byte_master.sv ====
// Mode 0 SPI master that exchanges one byte, MSB first, for each start request
`timescale 1ns/1ps

module spi_byte_master
    import sd_pkg::*;
#(
    parameter int spi_half_period = 64
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  spi_req_t req,
    input  logic     miso,
    output spi_rsp_t rsp,
    output logic     busy,
    output logic     sclk,
    output logic     mosi
);

    localparam int div_w = $clog2(spi_half_period + 1);

    logic [div_w-1:0] div_cnt;
    logic [3:0]       edge_cnt;
    logic [7:0]       shifter;
    logic             miso_bit;
    logic             done;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy     <= 1'b0;
            sclk     <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
            shifter  <= '0;
            miso_bit <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;

            if (!busy) begin
                // MSB is on MOSI before the first rising edge
                if (req.start) begin
                    busy     <= 1'b1;
                    shifter  <= req.tx_byte;
                    div_cnt  <= '0;
                    edge_cnt <= '0;
                end
            end else if (div_cnt == div_w'(spi_half_period - 1)) begin
                div_cnt  <= '0;
                sclk     <= ~sclk;
                edge_cnt <= edge_cnt + 1'b1;

                if (!sclk) begin
                    // Rising edge, sample the card
                    miso_bit <= miso;
                end else begin
                    // Falling edge, next bit out and sampled bit in
                    shifter <= {shifter[6:0], miso_bit};
                    if (edge_cnt == 4'd15) begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    assign mosi = shifter[7];

    // Shifter holds the received byte once all 8 bits are in
    assign rsp.done    = done;
    assign rsp.rx_byte = shifter;

endmodule

// ==== logic/sd_cmd_sequencer.sv ====
// Probe control: power-up delay, banner strobe, CMD0 frame, R1 polling and result report
`timescale 1ns/1ps

module sd_cmd_sequencer
    import sd_pkg::*;
#(
    parameter int startup_cycles = 4_000_000
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  spi_rsp_t   spi_rsp,
    input  logic       spi_busy,
    output spi_req_t   spi_req,
    output logic       ss_n,
    output logic       banner,
    output r1_result_t result
);

    localparam int delay_w = $clog2(startup_cycles + 1);
    localparam int poll_w  = $clog2(max_polls + 1);

    typedef enum logic [2:0] {
        st_delay,
        st_banner,
        st_frame_issue,
        st_frame_wait,
        st_poll_issue,
        st_poll_wait,
        st_done
    } state_t;

    state_t             state;
    logic [delay_w-1:0] delay_cnt;
    logic [2:0]         frame_idx;
    logic [poll_w-1:0]  poll_cnt;
    r1_t                rx_r1;

    // Polled byte seen through the R1 flag layout
    assign rx_r1.raw = spi_rsp.rx_byte;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state     <= st_delay;
            delay_cnt <= '0;
            frame_idx <= '0;
            poll_cnt  <= '0;
            spi_req   <= '0;
            ss_n      <= 1'b1;
            banner    <= 1'b0;
            result    <= '0;
        end else begin
            spi_req.start <= 1'b0;
            banner        <= 1'b0;
            result.valid  <= 1'b0;

            case (state)
                st_delay: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == delay_w'(startup_cycles - 1)) begin
                        state <= st_banner;
                    end
                end

                st_banner: begin
                    banner <= 1'b1;
                    state  <= st_frame_issue;
                end

                // ====================================================
                // CMD0 frame, one byte per transfer
                // ====================================================
                st_frame_issue: begin
                    if (!spi_busy) begin
                        spi_req.start   <= 1'b1;
                        spi_req.tx_byte <= cmd0_frame[frame_idx];
                        ss_n            <= 1'b0;
                        state           <= st_frame_wait;
                    end
                end

                st_frame_wait: begin
                    if (spi_rsp.done) begin
                        if (frame_idx == 3'(cmd0_len - 1)) begin
                            state <= st_poll_issue;
                        end else begin
                            frame_idx <= frame_idx + 1'b1;
                            state     <= st_frame_issue;
                        end
                    end
                end

                // ====================================================
                // Fill bytes until R1 or the poll limit
                // ====================================================
                st_poll_issue: begin
                    if (!spi_busy) begin
                        spi_req.start   <= 1'b1;
                        spi_req.tx_byte <= 8'hFF;
                        state           <= st_poll_wait;
                    end
                end

                st_poll_wait: begin
                    if (spi_rsp.done) begin
                        poll_cnt <= poll_cnt + 1'b1;
                        if (!rx_r1.flags.start_bit) begin
                            result.valid   <= 1'b1;
                            result.timeout <= 1'b0;
                            result.r1      <= rx_r1;
                            ss_n           <= 1'b1;
                            state          <= st_done;
                        end else if (poll_cnt == poll_w'(max_polls - 1)) begin
                            result.valid   <= 1'b1;
                            result.timeout <= 1'b1;
                            result.r1      <= rx_r1;
                            ss_n           <= 1'b1;
                            state          <= st_done;
                        end else begin
                            state <= st_poll_issue;
                        end
                    end
                end

                // One probe per reset
                default: state <= st_done;
            endcase
        end
    end

endmodule

// ==== logic/dbg_pkg.sv ====
// Debug line character type and ASCII constants, imported by the reporter and the serial transmitter
package dbg_pkg;

    typedef struct packed {
        logic       valid;
        logic [7:0] code;
    } dbg_char_t;

    // Banner printed before the probe
    localparam int banner_len = 3;
    localparam logic [0:banner_len-1][7:0] banner_text = "SD ";

    localparam logic [7:0] ascii_lf      = 8'h0A;
    localparam logic [7:0] ascii_dash    = 8'h2D;

    // Bases for hex digit conversion
    localparam logic [7:0] ascii_zero    = 8'h30;
    localparam logic [7:0] ascii_upper_a = 8'h41;

endpackage

// ==== logic/sd_pkg.sv ====
// SD card SPI-mode types, imported by the sequencer, the SPI master and the top level
package sd_pkg;

    // ============================================================
    // CMD0 frame and polling limits
    // ============================================================
    localparam int cmd0_len = 6;

    // GO_IDLE_STATE with its fixed CRC
    localparam logic [0:cmd0_len-1][7:0] cmd0_frame = {
        8'h40, 8'h00, 8'h00, 8'h00, 8'h00, 8'h95
    };

    // Fill bytes sent before giving up on R1
    localparam int max_polls = 8;

    // ============================================================
    // Byte transfer handshake
    // ============================================================
    typedef struct packed {
        logic       start;
        logic [7:0] tx_byte;
    } spi_req_t;

    typedef struct packed {
        logic       done;
        logic [7:0] rx_byte;
    } spi_rsp_t;

    // ============================================================
    // R1 response, as a byte or as flags
    // ============================================================
    typedef struct packed {
        logic start_bit;
        logic param_err;
        logic addr_err;
        logic erase_seq_err;
        logic crc_err;
        logic illegal_cmd;
        logic erase_reset;
        logic in_idle;
    } r1_flags_t;

    typedef union packed {
        logic [7:0] raw;
        r1_flags_t  flags;
    } r1_t;

    typedef struct packed {
        logic valid;
        logic timeout;
        r1_t  r1;
    } r1_result_t;

endpackage
